// File: rtl/residue_settings.svh
`ifndef RESIDUE_SETTINGS_SVH
`define RESIDUE_SETTINGS_SVH

// operand layout, 33 six-bit digits under a 2-bit top digit
`define OPERAND_W   200
`define DIGIT_W     6
`define DIGIT_COUNT 33
`define TOP_W       2

// modulus and residue width
`define MODULUS     461
`define RESIDUE_W   9

`endif

// File: rtl/operand_pkg.sv
`include "residue_settings.svh"

package operand_pkg;

  typedef logic [`DIGIT_W-1:0] digit_t;

  // digits[0] holds the least significant bits
  typedef struct packed {
    logic [`TOP_W-1:0]         top;
    digit_t [`DIGIT_COUNT-1:0] digits;
  } operand_digits_t;

  // same 200 bits, seen flat or split into digits
  typedef union packed {
    logic [`OPERAND_W-1:0] flat;
    operand_digits_t       view;
  } operand_t;

endpackage

// File: rtl/residue_pkg.sv
`include "residue_settings.svh"

package residue_pkg;

  // value below the modulus
  typedef logic [`RESIDUE_W-1:0] residue_t;

  // width of the last tree level
  typedef logic [`RESIDUE_W+3:0] half_sum_t;

  // 2^(6k) mod 461, built one digit step at a time
  function automatic int unsigned digit_weight(input int unsigned index);
    int unsigned w;
    int unsigned k;
    w = 1;
    for (k = 0; k < index; k++)
    begin
      w = (w << `DIGIT_W) % `MODULUS;
    end
    return w;
  endfunction

endpackage

// File: rtl/digit_weight_lut.sv
`include "residue_settings.svh"

module digit_weight_lut #(
  parameter int DIGIT_INDEX = 1
) (
  input  logic [`DIGIT_W-1:0]  digit,
  output residue_pkg::residue_t weighted
);

  localparam int unsigned WEIGHT = residue_pkg::digit_weight(DIGIT_INDEX);
  localparam int unsigned ENTRIES = 2 ** `DIGIT_W;

  typedef logic [ENTRIES-1:0][`RESIDUE_W-1:0] table_t;

  // entry d holds d * weight mod 461
  function automatic table_t build_table();
    table_t      t;
    int unsigned d;
    for (d = 0; d < ENTRIES; d++)
    begin
      t[d] = `RESIDUE_W'((d * WEIGHT) % `MODULUS);
    end
    return t;
  endfunction

  localparam table_t TABLE = build_table();

  // top digit uses only the first four entries
  assign weighted = TABLE[digit];

endmodule

// File: rtl/digit_sum_tree.sv
`include "residue_settings.svh"

module digit_sum_tree (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  operand_pkg::operand_t  operand,
  output residue_pkg::half_sum_t sum_lo,
  output residue_pkg::half_sum_t sum_hi,
  output logic                   sum_valid
);

  localparam int GROUPS = `DIGIT_COUNT / 3;

  // index 1 to 32 are full digits, 33 is the top digit
  residue_pkg::residue_t weighted [1:`DIGIT_COUNT];

  logic [10:0] group_sum [0:GROUPS-1];
  logic [11:0] quad_sum [0:3];

  residue_pkg::half_sum_t half_lo;
  residue_pkg::half_sum_t half_hi;

  genvar gd;
  genvar gg;

  generate
    for (gd = 1; gd <= `DIGIT_COUNT; gd++)
    begin : g_digit
      logic [`DIGIT_W-1:0] digit;

      if (gd < `DIGIT_COUNT)
      begin : g_full
        assign digit = operand.view.digits[gd];
      end
      else
      begin : g_top
        assign digit = {{(`DIGIT_W-`TOP_W){1'b0}}, operand.view.top};
      end

      digit_weight_lut #(
        .DIGIT_INDEX(gd)
      ) u_lut (
        .digit   (digit),
        .weighted(weighted[gd])
      );
    end
  endgenerate

  // first level, three tables per sum
  generate
    for (gg = 0; gg < GROUPS; gg++)
    begin : g_group
      assign group_sum[gg] = 11'(weighted[3*gg+1])
                           + 11'(weighted[3*gg+2])
                           + 11'(weighted[3*gg+3]);
    end
  endgenerate

  // second level, digit 0 rides in the last group
  assign quad_sum[0] = 12'(group_sum[0]) + 12'(group_sum[1]) + 12'(group_sum[2]);
  assign quad_sum[1] = 12'(group_sum[3]) + 12'(group_sum[4]) + 12'(group_sum[5]);
  assign quad_sum[2] = 12'(group_sum[6]) + 12'(group_sum[7]) + 12'(group_sum[8]);
  assign quad_sum[3] = 12'(group_sum[9]) + 12'(group_sum[10])
                     + 12'(operand.view.digits[0]);

  assign half_lo = 13'(quad_sum[0]) + 13'(quad_sum[1]);
  assign half_hi = 13'(quad_sum[2]) + 13'(quad_sum[3]);

  always_ff @(posedge clk)
  begin
    if (rst)
      sum_valid <= 1'b0;
    else
      sum_valid <= in_valid;
  end

  // half sums only load with a valid operand
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      sum_lo <= half_lo;
      sum_hi <= half_hi;
    end
  end

endmodule

// File: rtl/residue_fold.sv
`include "residue_settings.svh"

module residue_fold (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sum_valid,
  input  residue_pkg::half_sum_t sum_lo,
  input  residue_pkg::half_sum_t sum_hi,
  output logic                   out_valid,
  output residue_pkg::residue_t  residue
);

  // 512 mod 461
  localparam int FOLD_K = (1 << `RESIDUE_W) - `MODULUS;
  localparam logic [9:0] MOD_10 = 10'(`MODULUS);

  // each folded half is at most 511 + 15 * 51 = 1276
  logic [10:0] fold_lo;
  logic [10:0] fold_hi;
  logic [11:0] fold_1;
  logic [9:0]  fold_2;

  residue_pkg::residue_t corrected;

  assign fold_lo = 11'(sum_lo[`RESIDUE_W-1:0])
                 + 11'(sum_lo[12:`RESIDUE_W]) * 11'(FOLD_K);
  assign fold_hi = 11'(sum_hi[`RESIDUE_W-1:0])
                 + 11'(sum_hi[12:`RESIDUE_W]) * 11'(FOLD_K);

  assign fold_1 = 12'(fold_lo) + 12'(fold_hi);

  // second fold lands at most at 511 + 7 * 51 = 868
  assign fold_2 = 10'(fold_1[`RESIDUE_W-1:0])
                + 10'(fold_1[11:`RESIDUE_W]) * 10'(FOLD_K);

  // one subtraction is enough below 922
  always_comb
  begin
    if (fold_2 >= MOD_10)
      corrected = residue_pkg::residue_t'(fold_2 - MOD_10);
    else
      corrected = fold_2[`RESIDUE_W-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= sum_valid;
  end

  always_ff @(posedge clk)
  begin
    if (sum_valid)
      residue <= corrected;
  end

endmodule

// File: rtl/residue_461_top.sv
`include "residue_settings.svh"

module residue_461_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [`OPERAND_W-1:0] operand,
  output logic                  out_valid,
  output residue_pkg::residue_t residue
);

  operand_pkg::operand_t  operand_u;
  residue_pkg::half_sum_t sum_lo;
  residue_pkg::half_sum_t sum_hi;
  logic                   sum_valid;

  // flat port word into the digit view
  assign operand_u.flat = operand;

  // stage 1, tables and adder tree
  digit_sum_tree u_sum_tree (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .operand  (operand_u),
    .sum_lo   (sum_lo),
    .sum_hi   (sum_hi),
    .sum_valid(sum_valid)
  );

  // stage 2, fold and correct
  residue_fold u_fold (
    .clk      (clk),
    .rst      (rst),
    .sum_valid(sum_valid),
    .sum_lo   (sum_lo),
    .sum_hi   (sum_hi),
    .out_valid(out_valid),
    .residue  (residue)
  );

endmodule

// File: test/residue_461_checker.sv
`include "residue_settings.svh"

module residue_461_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid,
  input logic                  out_valid,
  input logic [`RESIDUE_W-1:0] residue
);

  residue_range: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> residue < `MODULUS)
    else $error("residue %0d is not below the modulus", residue);

  // one cycle per stage, two in all
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    $past(in_valid, 2) |-> out_valid)
    else $error("out_valid missing two cycles after in_valid");

  valid_source: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid, 2))
    else $error("out_valid without in_valid two cycles before");

  reset_clears: assert property (@(posedge clk)
    $past(rst) |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind residue_461_top residue_461_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .residue  (residue)
);

// File: test/residue_461_tb.sv
`include "residue_settings.svh"

module residue_461_tb;

  localparam int MAX_WAIT   = 10;
  localparam int STREAM_LEN = 40;
  localparam int IDLE_LEN   = 6;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic [`OPERAND_W-1:0] operand;
  logic                  out_valid;
  residue_pkg::residue_t residue;

  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;
  int          test_count;
  int          test_first_error;
  int          cycle;

  // operands in flight during the stream test
  int unsigned expected_q[$];
  int          issue_q[$];

  residue_461_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .operand  (operand),
    .out_valid(out_valid),
    .residue  (residue)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // seven draws, upper 24 bits dropped
  function automatic logic [`OPERAND_W-1:0] random_operand();
    logic [223:0] wide;
    int           i;
    for (i = 0; i < 7; i++)
    begin
      wide[32*i +: 32] = next_random();
    end
    return wide[`OPERAND_W-1:0];
  endfunction

  // doubling from the top bit down, mod 461 at every step
  function automatic int unsigned reference_residue(input logic [`OPERAND_W-1:0] value);
    int unsigned r;
    int          i;
    r = 0;
    for (i = `OPERAND_W - 1; i >= 0; i--)
    begin
      r = (2 * r + int'(value[i])) % `MODULUS;
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
      error_count++;
      $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  // inputs change 2 units after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    cycle++;
  endtask

  task automatic start_test();
    test_first_error = error_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s finished with %0d errors", test_count, name,
             error_count - test_first_error);
  endtask

  task automatic run_expect(input logic [`OPERAND_W-1:0] value, input int unsigned expected);
    int edges;
    next_cycle();
    in_valid = 1'b1;
    operand  = value;
    edges    = 0;
    do
    begin
      next_cycle();
      // scrambled operand must not reach the result
      in_valid = 1'b0;
      operand  = ~value;
      edges++;
    end
    while (!out_valid && edges < MAX_WAIT);
    if (!out_valid)
    begin
      error_count++;
      $display("No out_valid came within %0d cycles of an operand", MAX_WAIT);
    end
    else
    begin
      compare_value("latency", edges, 2);
      compare_value("residue", residue, expected);
    end
  endtask

  task automatic run_single(input logic [`OPERAND_W-1:0] value);
    run_expect(value, reference_residue(value));
  endtask

  // pop one result if out_valid is high this cycle
  task automatic collect_result();
    if (out_valid)
    begin
      if (expected_q.size() == 0)
      begin
        error_count++;
        $display("out_valid went high at time %0t with no operand in flight", $time);
      end
      else
      begin
        compare_value("latency", cycle - issue_q.pop_front(), 2);
        compare_value("residue", residue, expected_q.pop_front());
      end
    end
  endtask

  task automatic reset_idle_zero();
    int i;
    start_test();
    // reset lands while an operand is in flight
    next_cycle();
    in_valid = 1'b1;
    operand  = random_operand();
    next_cycle();
    in_valid = 1'b0;
    rst      = 1'b1;
    for (i = 0; i < 2; i++)
    begin
      next_cycle();
      compare_value("out_valid", out_valid, 0);
    end
    rst = 1'b0;
    for (i = 0; i < IDLE_LEN; i++)
    begin
      next_cycle();
      compare_value("out_valid", out_valid, 0);
    end
    run_expect('0, 0);
    finish_test("reset in flight, idle and zero");
  endtask

  task automatic small_values_pass_through();
    int unsigned v;
    start_test();
    for (v = 0; v < `MODULUS; v++)
    begin
      run_expect(`OPERAND_W'(v), v);
    end
    run_expect(`OPERAND_W'(461), 0);
    run_expect(`OPERAND_W'(922), 0);
    finish_test("values below the modulus");
  endtask

  task automatic powers_of_two();
    logic [`OPERAND_W-1:0] value;
    int                    i;
    start_test();
    for (i = 0; i < `OPERAND_W; i++)
    begin
      value    = '0;
      value[i] = 1'b1;
      run_single(value);
    end
    finish_test("powers of two");
  endtask

  task automatic dense_patterns();
    start_test();
    run_single({`OPERAND_W{1'b1}});
    run_single({25{8'haa}});
    run_single({25{8'h55}});
    run_single({50{4'hc}});
    run_single({50{4'h3}});
    run_single({{100{1'b1}}, {100{1'b0}}});
    run_single({{100{1'b0}}, {100{1'b1}}});
    finish_test("all ones and alternating");
  endtask

  task automatic random_stream();
    logic [`OPERAND_W-1:0] value;
    int                    n;
    int                    waited;
    start_test();
    expected_q.delete();
    issue_q.delete();
    for (n = 0; n < STREAM_LEN; n++)
    begin
      next_cycle();
      collect_result();
      value    = random_operand();
      in_valid = 1'b1;
      operand  = value;
      expected_q.push_back(reference_residue(value));
      issue_q.push_back(cycle);
    end
    waited = 0;
    while (expected_q.size() != 0 && waited < MAX_WAIT)
    begin
      next_cycle();
      in_valid = 1'b0;
      collect_result();
      waited++;
    end
    if (expected_q.size() != 0)
    begin
      error_count++;
      $display("%0d stream results never arrived", expected_q.size());
    end
    finish_test("back to back random");
  endtask

  task automatic invalid_operand_ignored();
    int i;
    start_test();
    next_cycle();
    in_valid = 1'b0;
    operand  = random_operand();
    for (i = 0; i < IDLE_LEN; i++)
    begin
      next_cycle();
      operand = random_operand();
      compare_value("out_valid", out_valid, 0);
    end
    finish_test("operand without in_valid");
  endtask

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    operand     = '0;
    lcg_state   = 32'h2a4d;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    cycle       = 0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    reset_idle_zero();
    small_values_pass_through();
    powers_of_two();
    dense_patterns();
    random_stream();
    invalid_operand_ignored();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/operand_pkg.sv
rtl/residue_pkg.sv
rtl/digit_weight_lut.sv
rtl/digit_sum_tree.sv
rtl/residue_fold.sv
rtl/residue_461_top.sv
test/residue_461_checker.sv
test/residue_461_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module residue_461_tb -o residue_461_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/residue_461_sim)
echo "$out"
echo "$out" | grep -q "Everything OK" && exit 0 || exit 1
